//--- sim.f
src/calc_pkg.sv
src/key_filter.sv
src/entry_fsm.sv
src/calc_alu.sv
src/display_sel.sv
src/calc_top.sv
dv/calc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the calculator testbench with Verilator
set -u

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary -f sim.f --top-module calc_tb -Mdir "$BUILD_DIR" -o calc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/calc_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0

//--- dv/calc_tb.sv
`default_nettype none

module calc_tb
    import calc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD       = 8;
    localparam int STIM_DLY     = 1;     // after the rising edge
    localparam int RESET_CYCLES = 5;
    localparam int GAP          = 4;     // cycles between key bytes
    localparam int MAX_KEYS     = 12;
    localparam int N_ROWS       = 17;
    // two Enter bytes lead every row
    localparam int TIMEOUT_NS   = 2 * N_ROWS * (MAX_KEYS + 2) * GAP * PERIOD;

    logic        clk;
    logic        iRST_n;
    logic [7:0]  key_byte;
    logic        key_valid;
    seg_digits_t seg;
    bcd_num_t    display_bcd;

    // stimulus table
    string    row_name [N_ROWS];
    string    row_keys [N_ROWS];
    bcd_num_t row_exp  [N_ROWS];
    int       n_rows;

    logic [6:0] seg_ref [16];    // expected active-low patterns, g..a

    calc_top u_dut (
        .clk         (clk),
        .iRST_n      (iRST_n),
        .key_byte    (key_byte),
        .key_valid   (key_valid),
        .seg         (seg),
        .display_bcd (display_bcd)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic check(input string name, input logic [BCD_W-1:0] expected,
                         input logic [BCD_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // table characters to scan codes
    function automatic logic [7:0] scan_code(input logic [7:0] c);
        case (c)
            "0":     return SC_0;
            "1":     return SC_1;
            "2":     return SC_2;
            "3":     return SC_3;
            "4":     return SC_4;
            "5":     return SC_5;
            "6":     return SC_6;
            "7":     return SC_7;
            "8":     return SC_8;
            "9":     return SC_9;
            "+":     return SC_ADD;
            "-":     return SC_SUB;
            "*":     return SC_MUL;
            "/":     return SC_DIV;
            "b":     return SC_BACK;
            " ":     return SC_SPACE;
            "=":     return SC_ENTER;
            "r":     return SC_BREAK;   // release prefix
            default: return 8'h00;      // not a key code
        endcase
    endfunction

    task automatic add_row(input string name, input string keys, input bcd_num_t exp_bcd);
        row_name[n_rows] = name;
        row_keys[n_rows] = keys;
        row_exp[n_rows]  = exp_bcd;
        n_rows++;
    endtask

    // one strobe, then wait out the gap
    task automatic send_byte(input logic [7:0] code);
        key_byte  = code;
        key_valid = 1'b1;
        @(posedge clk);
        #STIM_DLY;
        key_valid = 1'b0;
        repeat (GAP - 1) @(posedge clk);
        #STIM_DLY;
    endtask

    task automatic run_row(input int r);
        string    keys;
        bcd_num_t exp_bcd;
        keys    = row_keys[r];
        exp_bcd = row_exp[r];
        send_byte(SC_ENTER);        // back to idle
        send_byte(SC_ENTER);
        for (int i = 0; i < keys.len(); i++) begin
            send_byte(scan_code(keys[i]));
        end
        check(row_name[r], exp_bcd, display_bcd);
        for (int d = 0; d < NUM_DIGITS; d++) begin
            check($sformatf("%s seg%0d", row_name[r], d),
                  BCD_W'(seg_ref[exp_bcd[d*4 +: 4]]), BCD_W'(seg[d]));
        end
    endtask

    // ----------------------------------------
    // table
    // ----------------------------------------
    // keys: digits, + - * /, b backspace, space, = enter, r release prefix
    task automatic load_rows();
        n_rows = 0;
        add_row("seven_digits",  "1234567",    24'h123456);
        add_row("backspace",     "123bbb",     24'h000000);
        add_row("backspace_one", "456b",       24'h000045);
        add_row("add",           "123+456=",   24'h000579);
        add_row("mul",           "25*4=",      24'h000100);
        add_row("add_overflow",  "999999+1=",  24'h00000E);
        add_row("mul_overflow",  "1000*1000=", 24'h00000E);
        add_row("sub_positive",  "12-5=",      24'h000007);
        add_row("sub_negative",  "5-12=",      24'hF00007);
        add_row("sub_neg_range", "0-100000=",  24'h00000E);
        add_row("div_quotient",  "100/7=",     24'h000014);
        add_row("div_remainder", "100/7= ",    24'h000002);
        add_row("div_toggle",    "100/7=  ",   24'h000014);
        add_row("div_by_zero",   "5/0=",       24'h00000E);
        add_row("break_code",    "1r12",       24'h000012);
        add_row("op_in_idle",    "+4+5=",      24'h000009);
        add_row("enter_clears",  "2+3==",      24'h000000);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        clk       = 1'b0;
        iRST_n    = 1'b0;
        key_byte  = 8'h00;
        key_valid = 1'b0;
        seg_ref = '{7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
                    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
                    7'b0000000, 7'b0010000, 7'b1111111, 7'b1111111,
                    7'b1111111, 7'b1111111, 7'b0000110, 7'b0111111};
        load_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        #STIM_DLY;
        iRST_n = 1'b1;
        check("reset", '0, display_bcd);
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("all tests passed");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("error: the run timed out after %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- src/calc_top.sv
`default_nettype none

module calc_top
    import calc_pkg::*;
(
    input  logic        clk,
    input  logic        iRST_n,
    input  logic [7:0]  key_byte,     // scan code byte
    input  logic        key_valid,    // one-cycle strobe
    output seg_digits_t seg,
    output bcd_num_t    display_bcd
);

    key_event_t    key_evt;
    alu_req_t      alu_req;
    alu_res_t      alu_res;
    entry_status_t status;

    // ----------------------------------------
    // key path
    // ----------------------------------------
    key_filter u_key_filter (
        .clk       (clk),
        .iRST_n    (iRST_n),
        .key_byte  (key_byte),
        .key_valid (key_valid),
        .key_evt   (key_evt)
    );

    entry_fsm u_entry_fsm (
        .clk     (clk),
        .iRST_n  (iRST_n),
        .key_evt (key_evt),
        .alu_req (alu_req),
        .status  (status)
    );

    // works beside the entry FSM
    calc_alu u_calc_alu (
        .clk     (clk),
        .iRST_n  (iRST_n),
        .alu_req (alu_req),
        .alu_res (alu_res)
    );

    display_sel u_display_sel (
        .status      (status),
        .alu_res     (alu_res),
        .seg         (seg),
        .display_bcd (display_bcd)
    );

endmodule

`default_nettype wire

//--- src/display_sel.sv
`default_nettype none

module display_sel
    import calc_pkg::*;
(
    input  entry_status_t status,
    input  alu_res_t      alu_res,
    output seg_digits_t   seg,
    output bcd_num_t      display_bcd
);

    bcd_num_t shown;

    // ----------------------------------------
    // number select
    // ----------------------------------------
    always_comb begin
        case (status.state)
            ST_RESULT: begin
                if (alu_res.error) begin
                    shown = BCD_W'(NIB_ERR);            // 00000E
                end else if (alu_res.negative) begin
                    // minus sign over the lower five digits
                    shown = {NIB_MINUS, alu_res.result[BCD_W-5:0]};
                end else if (status.is_div && status.show_rem) begin
                    shown = alu_res.remainder;
                end else begin
                    shown = alu_res.result;
                end
            end
            ST_SECOND: shown = status.second;
            default:   shown = status.first;   // idle shows the cleared first operand
        endcase
    end

    assign display_bcd = shown;

    // ----------------------------------------
    // segment drive
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            seg[i] = seg7_of(shown[i*4 +: 4]);
        end
    end

endmodule

`default_nettype wire

//--- src/calc_alu.sv
`default_nettype none

module calc_alu
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     iRST_n,
    input  alu_req_t alu_req,
    output alu_res_t alu_res
);

    logic [BIN_W-1:0]   a;
    logic [BIN_W-1:0]   b;
    logic [BIN_W:0]     sum;        // one carry bit
    logic [2*BIN_W-1:0] prod;       // full width for the range check
    logic [BIN_W-1:0]   value;
    logic [BIN_W-1:0]   rem_val;
    logic               err;
    logic               neg;

    bcd_num_t res_q;
    bcd_num_t rem_q;
    logic     err_q;
    logic     neg_q;

    assign a = alu_req.a;
    assign b = alu_req.b;

    // ----------------------------------------
    // arithmetic and range rules
    // ----------------------------------------
    always_comb begin
        sum     = {1'b0, a} + {1'b0, b};
        prod    = {{BIN_W{1'b0}}, a} * {{BIN_W{1'b0}}, b};
        value   = '0;
        rem_val = '0;
        err     = 1'b0;
        neg     = 1'b0;
        case (alu_req.op)
            OP_ADD: begin
                value = sum[BIN_W-1:0];
                err   = sum > (BIN_W+1)'(MAX_VALUE);
            end
            OP_SUB: begin
                if (a >= b) begin
                    value = a - b;
                end else begin
                    value = b - a;              // magnitude, sign kept apart
                    neg   = 1'b1;
                    err   = value > BIN_W'(MAX_NEG);
                end
            end
            OP_MUL: begin
                value = prod[BIN_W-1:0];
                err   = prod > (2*BIN_W)'(MAX_VALUE);
            end
            OP_DIV: begin
                if (b == '0) begin
                    err = 1'b1;
                end else begin
                    value   = a / b;
                    rem_val = a % b;
                end
            end
        endcase
    end

    // flags
    always_ff @(posedge clk or negedge iRST_n) begin
        if (!iRST_n) begin
            err_q <= 1'b0;
            neg_q <= 1'b0;
        end else if (alu_req.start) begin
            err_q <= err;
            neg_q <= neg & ~err;
        end
    end

    // held in BCD until the next start
    always_ff @(posedge clk) begin
        if (alu_req.start) begin
            res_q <= err ? '0 : bin_to_bcd(value);
            rem_q <= err ? '0 : bin_to_bcd(rem_val);
        end
    end

    always_comb begin
        alu_res.result    = res_q;
        alu_res.remainder = rem_q;
        alu_res.error     = err_q;
        alu_res.negative  = neg_q;
    end

endmodule

`default_nettype wire

//--- src/entry_fsm.sv
`default_nettype none

module entry_fsm
    import calc_pkg::*;
(
    input  logic          clk,
    input  logic          iRST_n,
    input  key_event_t    key_evt,
    output alu_req_t      alu_req,
    output entry_status_t status
);

    entry_state_e state;
    bcd_num_t     first_num;
    bcd_num_t     second_num;
    op_e          op;
    logic         is_div;
    logic         show_rem;
    logic         start_pulse;

    // new digit enters at the bottom, only while there is room
    function automatic bcd_num_t push_digit(input bcd_num_t num, input logic [3:0] dig);
        if (num[BCD_W-1 -: 4] != 4'h0)
            return num;
        return {num[BCD_W-5:0], dig};
    endfunction

    function automatic bcd_num_t pop_digit(input bcd_num_t num);
        return {4'h0, num[BCD_W-1:4]};
    endfunction

    function automatic op_e op_of(input key_kind_e kind);
        case (kind)
            KEY_SUB: return OP_SUB;
            KEY_MUL: return OP_MUL;
            KEY_DIV: return OP_DIV;
            default: return OP_ADD;
        endcase
    endfunction

    // ----------------------------------------
    // key handling
    // ----------------------------------------
    always_ff @(posedge clk or negedge iRST_n) begin
        if (!iRST_n) begin
            state       <= ST_IDLE;
            first_num   <= '0;
            second_num  <= '0;
            op          <= OP_ADD;
            is_div      <= 1'b0;
            show_rem    <= 1'b0;
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= 1'b0;
            if (key_evt.valid) begin
                case (key_evt.kind)
                    KEY_DIGIT: begin
                        case (state)
                            ST_IDLE: begin
                                first_num <= BCD_W'(key_evt.digit);
                                state     <= ST_FIRST;
                            end
                            ST_FIRST:  first_num  <= push_digit(first_num, key_evt.digit);
                            ST_SECOND: second_num <= push_digit(second_num, key_evt.digit);
                            default:   ;            // result stays until Enter
                        endcase
                    end
                    KEY_ADD, KEY_SUB, KEY_MUL, KEY_DIV: begin
                        if (state == ST_FIRST) begin
                            op     <= op_of(key_evt.kind);
                            is_div <= (key_evt.kind == KEY_DIV);
                            state  <= ST_SECOND;
                        end
                    end
                    KEY_BACK: begin
                        if (state == ST_FIRST) begin
                            first_num <= pop_digit(first_num);
                            if (first_num[BCD_W-1:4] == '0)
                                state <= ST_IDLE;
                        end else if (state == ST_SECOND) begin
                            second_num <= pop_digit(second_num);
                            if (second_num[BCD_W-1:4] == '0) begin
                                // operand gone, drop the operator too
                                state  <= ST_FIRST;
                                op     <= OP_ADD;
                                is_div <= 1'b0;
                            end
                        end
                    end
                    KEY_SPACE: begin
                        if (state == ST_RESULT && is_div)
                            show_rem <= ~show_rem;  // quotient <-> remainder
                    end
                    KEY_ENTER: begin
                        if (state == ST_SECOND) begin
                            start_pulse <= 1'b1;
                            show_rem    <= 1'b0;
                            state       <= ST_RESULT;
                        end else begin
                            state      <= ST_IDLE;  // clear all
                            first_num  <= '0;
                            second_num <= '0;
                            op         <= OP_ADD;
                            is_div     <= 1'b0;
                            show_rem   <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    // operands stay put in ST_RESULT, so the ALU sees stable inputs
    always_comb begin
        alu_req.start = start_pulse;
        alu_req.op    = op;
        alu_req.a     = bcd_to_bin(first_num);
        alu_req.b     = bcd_to_bin(second_num);
    end

    always_comb begin
        status.state    = state;
        status.first    = first_num;
        status.second   = second_num;
        status.is_div   = is_div;
        status.show_rem = show_rem;
    end

endmodule

`default_nettype wire

//--- src/key_filter.sv
`default_nettype none

module key_filter
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       iRST_n,
    input  logic [7:0] key_byte,
    input  logic       key_valid,
    output key_event_t key_evt
);

    logic       skip_next;   // set by the release prefix
    key_event_t dec;

    // make code lookup
    always_comb begin
        dec.valid = 1'b1;
        dec.kind  = KEY_DIGIT;
        dec.digit = 4'd0;
        case (key_byte)
            SC_0:     dec.digit = 4'd0;
            SC_1:     dec.digit = 4'd1;
            SC_2:     dec.digit = 4'd2;
            SC_3:     dec.digit = 4'd3;
            SC_4:     dec.digit = 4'd4;
            SC_5:     dec.digit = 4'd5;
            SC_6:     dec.digit = 4'd6;
            SC_7:     dec.digit = 4'd7;
            SC_8:     dec.digit = 4'd8;
            SC_9:     dec.digit = 4'd9;
            SC_ADD:   dec.kind  = KEY_ADD;
            SC_SUB:   dec.kind  = KEY_SUB;
            SC_MUL:   dec.kind  = KEY_MUL;
            SC_DIV:   dec.kind  = KEY_DIV;
            SC_BACK:  dec.kind  = KEY_BACK;
            SC_SPACE: dec.kind  = KEY_SPACE;
            SC_ENTER: dec.kind  = KEY_ENTER;
            default:  dec.valid = 1'b0;     // unknown code, no event
        endcase
    end

    always_ff @(posedge clk or negedge iRST_n) begin
        if (!iRST_n) begin
            skip_next <= 1'b0;
            key_evt   <= '0;
        end else begin
            key_evt.valid <= 1'b0;
            if (key_valid) begin
                if (key_byte == SC_BREAK) begin
                    skip_next <= 1'b1;
                end else if (skip_next) begin
                    skip_next <= 1'b0;      // released key, drop it
                end else begin
                    key_evt <= dec;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // ----------------------------------------
    // sizes and limits
    // ----------------------------------------
    localparam int NUM_DIGITS = 6;
    localparam int BCD_W      = 24;
    localparam int BIN_W      = 20;       // holds 999999
    localparam int MAX_VALUE  = 999999;
    localparam int MAX_NEG    = 99999;    // top digit is taken by the sign

    // scan codes, make side only
    localparam logic [7:0] SC_0     = 8'h70;
    localparam logic [7:0] SC_1     = 8'h69;
    localparam logic [7:0] SC_2     = 8'h72;
    localparam logic [7:0] SC_3     = 8'h7A;
    localparam logic [7:0] SC_4     = 8'h6B;
    localparam logic [7:0] SC_5     = 8'h73;
    localparam logic [7:0] SC_6     = 8'h74;
    localparam logic [7:0] SC_7     = 8'h6C;
    localparam logic [7:0] SC_8     = 8'h75;
    localparam logic [7:0] SC_9     = 8'h7D;
    localparam logic [7:0] SC_ADD   = 8'h79;
    localparam logic [7:0] SC_SUB   = 8'h7B;
    localparam logic [7:0] SC_MUL   = 8'h7C;
    localparam logic [7:0] SC_DIV   = 8'h4A;
    localparam logic [7:0] SC_BACK  = 8'h66;
    localparam logic [7:0] SC_SPACE = 8'h29;
    localparam logic [7:0] SC_ENTER = 8'h5A;
    localparam logic [7:0] SC_BREAK = 8'hF0;   // release prefix

    localparam logic [3:0] NIB_ERR   = 4'hE;
    localparam logic [3:0] NIB_MINUS = 4'hF;

    // ----------------------------------------
    // types
    // ----------------------------------------
    typedef enum logic [2:0] {
        KEY_DIGIT, KEY_ADD, KEY_SUB, KEY_MUL, KEY_DIV, KEY_BACK, KEY_SPACE, KEY_ENTER
    } key_kind_e;

    typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_MUL, OP_DIV} op_e;

    typedef enum logic [1:0] {ST_IDLE, ST_FIRST, ST_SECOND, ST_RESULT} entry_state_e;

    typedef logic [BCD_W-1:0] bcd_num_t;            // six nibbles, digit 0 at the bottom
    typedef logic [NUM_DIGITS-1:0][6:0] seg_digits_t;

    typedef struct packed {
        logic      valid;
        key_kind_e kind;
        logic [3:0] digit;
    } key_event_t;

    typedef struct packed {
        logic             start;
        op_e              op;
        logic [BIN_W-1:0] a;
        logic [BIN_W-1:0] b;
    } alu_req_t;

    typedef struct packed {
        bcd_num_t result;     // quotient for a division
        bcd_num_t remainder;
        logic     error;
        logic     negative;
    } alu_res_t;

    typedef struct packed {
        entry_state_e state;
        bcd_num_t     first;
        bcd_num_t     second;
        logic         is_div;
        logic         show_rem;
    } entry_status_t;

    // ----------------------------------------
    // conversions
    // ----------------------------------------
    function automatic logic [BIN_W-1:0] bcd_to_bin(input bcd_num_t bcd);
        logic [BIN_W-1:0] acc;
        acc = '0;
        for (int i = NUM_DIGITS - 1; i >= 0; i--) begin
            acc = acc * BIN_W'(10) + BIN_W'(bcd[i*4 +: 4]);
        end
        return acc;
    endfunction

    // double dabble, one input bit per pass
    function automatic bcd_num_t bin_to_bcd(input logic [BIN_W-1:0] bin);
        bcd_num_t bcd;
        bcd = '0;
        for (int i = BIN_W - 1; i >= 0; i--) begin
            for (int d = 0; d < NUM_DIGITS; d++) begin
                if (bcd[d*4 +: 4] >= 4'd5)
                    bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
            end
            bcd = {bcd[BCD_W-2:0], bin[i]};
        end
        return bcd;
    endfunction

    // active low, bits g..a
    function automatic logic [6:0] seg7_of(input logic [3:0] nib);
        case (nib)
            4'h0:      return 7'b1000000;
            4'h1:      return 7'b1111001;
            4'h2:      return 7'b0100100;
            4'h3:      return 7'b0110000;
            4'h4:      return 7'b0011001;
            4'h5:      return 7'b0010010;
            4'h6:      return 7'b0000010;
            4'h7:      return 7'b1111000;
            4'h8:      return 7'b0000000;
            4'h9:      return 7'b0010000;
            NIB_ERR:   return 7'b0000110;
            NIB_MINUS: return 7'b0111111;   // only g lit
            default:   return 7'b1111111;   // blank
        endcase
    endfunction

endpackage

`default_nettype wire
